//--- design/div_pkg.sv
package div_pkg;

    // ******************************
    // operand and queue word types.
    // ******************************
    typedef logic [63:0] xlen_t;  // full width operand or result.
    typedef logic [31:0] half_t;  // W form operand.

    localparam int CMD_W = 130;
    localparam int RES_W = 128;

    // {divw, signed, divisor, dividend}.
    typedef logic [CMD_W-1:0] cmd_word_t;

    // {quotient, remainder}.
    typedef logic [RES_W-1:0] res_word_t;

    // flags sit above the divisor (127..64) and the dividend (63..0).
    localparam int CMD_SIGNED_BIT = 128;
    localparam int CMD_DIVW_BIT   = 129;

    // ******************************
    // divider FSM.
    // ******************************
    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_DONE
    } div_state_e;

endpackage

//--- design/wb_pkg.sv
package wb_pkg;

    typedef logic [63:0] wb_data_t;
    typedef logic [2:0]  wb_addr_t;  // word address.

    // ******************************
    // register map.
    // ******************************
    localparam wb_addr_t REG_DIVIDEND  = 3'd0;  // write only.
    localparam wb_addr_t REG_DIVISOR   = 3'd1;  // write only.
    localparam wb_addr_t REG_CTRL      = 3'd2;  // write queues the operation.
    localparam wb_addr_t REG_QUOTIENT  = 3'd3;  // read without pop.
    localparam wb_addr_t REG_REMAINDER = 3'd4;  // read pops the result.
    localparam wb_addr_t REG_STATUS    = 3'd5;

    // control word bits.
    localparam int CTRL_SIGNED_BIT = 0;
    localparam int CTRL_DIVW_BIT   = 1;

    // status word bits.
    localparam int STAT_RESULT_BIT   = 0;
    localparam int STAT_CMD_FULL_BIT = 1;

endpackage

//--- design/op_fifo.sv
`timescale 1ns/100ps

module op_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    output logic             full,
    input  logic             pop,
    output logic [WIDTH-1:0] pop_data,
    output logic             empty
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW:0]      wr_ptr;  // extra msb tells full from empty.
    logic [AW:0]      rd_ptr;
    logic             do_push;
    logic             do_pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_push = push && !full;  // push on full is dropped.
    assign do_pop  = pop && !empty;

    // show-ahead head.
    assign pop_data = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_data;
        end
    end

endmodule

//--- design/div_core.sv
`timescale 1ns/100ps

module div_core (
    input  logic               clk,
    input  logic               rst,
    output logic               cmd_pop,
    input  div_pkg::cmd_word_t cmd_data,
    input  logic               cmd_empty,
    output logic               res_push,
    output div_pkg::res_word_t res_data,
    input  logic               res_full
);

    div_pkg::div_state_e state;
    logic [5:0]          cnt;
    logic [5:0]          last_cnt;

    // command fields.
    div_pkg::xlen_t a;
    div_pkg::xlen_t b;
    div_pkg::half_t a_w;
    div_pkg::half_t b_w;
    logic           sgn;
    logic           w;
    logic           a_neg;
    logic           b_neg;
    logic           zero_in;
    logic           ovf_in;
    div_pkg::xlen_t quo_ld;
    div_pkg::xlen_t dvs_ld;

    // latched operation.
    div_pkg::xlen_t rem;  // partial remainder.
    div_pkg::xlen_t quo;  // dividend shifts out, quotient shifts in.
    div_pkg::xlen_t dvs;  // divisor magnitude.
    div_pkg::xlen_t dvd;  // dividend as the special results need it.
    logic           is_w;
    logic           q_neg;
    logic           r_neg;
    logic           div_zero;
    logic           ovf;
    logic           special;

    logic [64:0]    shifted;
    logic [64:0]    diff;
    div_pkg::xlen_t q_fix;
    div_pkg::xlen_t r_fix;
    div_pkg::xlen_t q_out;
    div_pkg::xlen_t r_out;

    // ******************************
    // command decode.
    // ******************************
    assign a     = cmd_data[63:0];
    assign b     = cmd_data[127:64];
    assign sgn   = cmd_data[div_pkg::CMD_SIGNED_BIT];
    assign w     = cmd_data[div_pkg::CMD_DIVW_BIT];
    assign a_w   = a[31:0];  // upper bits ignored for W.
    assign b_w   = b[31:0];
    assign a_neg = sgn && (w ? a_w[31] : a[63]);
    assign b_neg = sgn && (w ? b_w[31] : b[63]);

    assign zero_in = w ? (b_w == '0) : (b == '0);
    assign ovf_in  = sgn && (w ? (a_w == {1'b1, 31'b0}) && (b_w == '1)
                               : (a == {1'b1, 63'b0}) && (b == '1));

    always_comb begin
        if (w) begin
            // W dividend sits high so 32 shifts bring it through.
            quo_ld = {(a_neg ? -a_w : a_w), 32'b0};
            dvs_ld = {32'b0, (b_neg ? -b_w : b_w)};
        end else begin
            quo_ld = a_neg ? -a : a;
            dvs_ld = b_neg ? -b : b;
        end
    end

    assign cmd_pop  = (state == div_pkg::S_IDLE) && !cmd_empty;
    assign res_push = (state == div_pkg::S_DONE) && !res_full;

    assign special  = div_zero || ovf;
    assign last_cnt = is_w ? 6'd31 : 6'd63;

    // ******************************
    // FSM.
    // ******************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= div_pkg::S_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                div_pkg::S_IDLE: begin
                    if (!cmd_empty) begin
                        state <= div_pkg::S_RUN;
                        cnt   <= '0;
                    end
                end
                div_pkg::S_RUN: begin
                    cnt <= cnt + 1;
                    // special cases leave right after the load cycle.
                    if (special || cnt == last_cnt) begin
                        state <= div_pkg::S_DONE;
                    end
                end
                div_pkg::S_DONE: begin
                    if (!res_full) begin
                        state <= div_pkg::S_IDLE;
                    end
                end
                default: state <= div_pkg::S_IDLE;
            endcase
        end
    end

    // restoring step gives one quotient bit.
    assign shifted = {rem, quo[63]};
    assign diff    = shifted - {1'b0, dvs};

    always_ff @(posedge clk) begin
        if (cmd_pop) begin
            rem      <= '0;
            quo      <= quo_ld;
            dvs      <= dvs_ld;
            dvd      <= w ? {{32{a_w[31]}}, a_w} : a;
            is_w     <= w;
            q_neg    <= a_neg ^ b_neg;
            r_neg    <= a_neg;  // remainder takes the dividend sign.
            div_zero <= zero_in;
            ovf      <= ovf_in;
        end else if (state == div_pkg::S_RUN && !special) begin
            if (!diff[64]) begin
                rem <= diff[63:0];
                quo <= {quo[62:0], 1'b1};
            end else begin
                rem <= shifted[63:0];  // borrow means the shifted value stays.
                quo <= {quo[62:0], 1'b0};
            end
        end
    end

    // ******************************
    // result fix-up.
    // ******************************
    always_comb begin
        q_fix = q_neg ? -quo : quo;
        r_fix = r_neg ? -rem : rem;
        if (is_w) begin
            q_fix = {{32{q_fix[31]}}, q_fix[31:0]};
            r_fix = {{32{r_fix[31]}}, r_fix[31:0]};
        end
        if (div_zero) begin
            q_out = '1;
            r_out = dvd;
        end else if (ovf) begin
            q_out = dvd;
            r_out = '0;
        end else begin
            q_out = q_fix;
            r_out = r_fix;
        end
    end

    assign res_data = {q_out, r_out};

endmodule

//--- design/wb_div_regs.sv
`timescale 1ns/100ps

module wb_div_regs (
    input  logic               clk,
    input  logic               rst,
    input  logic               cyc,
    input  logic               stb,
    input  logic               we,
    input  wb_pkg::wb_addr_t   adr,
    input  wb_pkg::wb_data_t   dat_w,
    output wb_pkg::wb_data_t   dat_r,
    output logic               ack,
    output logic               cmd_push,
    output div_pkg::cmd_word_t cmd_data,
    input  logic               cmd_full,
    output logic               res_pop,
    input  div_pkg::res_word_t res_data,
    input  logic               res_empty
);

    div_pkg::xlen_t   dividend;
    div_pkg::xlen_t   divisor;
    div_pkg::xlen_t   res_quo;
    div_pkg::xlen_t   res_rem;
    wb_pkg::wb_data_t status;
    wb_pkg::wb_data_t rd_data;
    logic             req;
    logic             ctrl_wr;
    logic             ack_next;

    assign req     = cyc && stb && !ack;  // request not yet answered.
    assign ctrl_wr = req && we && (adr == wb_pkg::REG_CTRL);

    // control writes wait for room in the command FIFO.
    assign cmd_push = ctrl_wr && !cmd_full;
    assign ack_next = ctrl_wr ? !cmd_full : req;

    assign res_pop = req && !we && (adr == wb_pkg::REG_REMAINDER) && !res_empty;

    assign {res_quo, res_rem} = res_data;

    always_comb begin
        cmd_data = {2'b00, divisor, dividend};
        cmd_data[div_pkg::CMD_DIVW_BIT]   = dat_w[wb_pkg::CTRL_DIVW_BIT];
        cmd_data[div_pkg::CMD_SIGNED_BIT] = dat_w[wb_pkg::CTRL_SIGNED_BIT];
    end

    // ******************************
    // read mux.
    // ******************************
    always_comb begin
        status = '0;
        status[wb_pkg::STAT_RESULT_BIT]   = !res_empty;
        status[wb_pkg::STAT_CMD_FULL_BIT] = cmd_full;
        case (adr)
            wb_pkg::REG_QUOTIENT:  rd_data = res_empty ? '0 : res_quo;
            wb_pkg::REG_REMAINDER: rd_data = res_empty ? '0 : res_rem;
            wb_pkg::REG_STATUS:    rd_data = status;
            default:               rd_data = '0;  // write-only registers.
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= ack_next;
        end
    end

    always_ff @(posedge clk) begin
        if (req && we && adr == wb_pkg::REG_DIVIDEND) begin
            dividend <= dat_w;
        end
        if (req && we && adr == wb_pkg::REG_DIVISOR) begin
            divisor <= dat_w;
        end
        if (req && !we) begin
            dat_r <= rd_data;  // valid with ack.
        end
    end

endmodule

//--- design/div_unit_top.sv
`timescale 1ns/100ps

module div_unit_top #(
    parameter int CMD_DEPTH = 4,
    parameter int RES_DEPTH = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             cyc,
    input  logic             stb,
    input  logic             we,
    input  wb_pkg::wb_addr_t adr,
    input  wb_pkg::wb_data_t dat_w,
    output wb_pkg::wb_data_t dat_r,
    output logic             ack
);

    logic               cmd_push;
    div_pkg::cmd_word_t cmd_in;
    logic               cmd_full;
    logic               cmd_pop;
    div_pkg::cmd_word_t cmd_head;
    logic               cmd_empty;

    logic               res_push;
    div_pkg::res_word_t res_in;
    logic               res_full;
    logic               res_pop;
    div_pkg::res_word_t res_head;
    logic               res_empty;

    wb_div_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .adr      (adr),
        .dat_w    (dat_w),
        .dat_r    (dat_r),
        .ack      (ack),
        .cmd_push (cmd_push),
        .cmd_data (cmd_in),
        .cmd_full (cmd_full),
        .res_pop  (res_pop),
        .res_data (res_head),
        .res_empty(res_empty)
    );

    op_fifo #(
        .WIDTH(div_pkg::CMD_W),
        .DEPTH(CMD_DEPTH)
    ) cmd_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (cmd_push),
        .push_data(cmd_in),
        .full     (cmd_full),
        .pop      (cmd_pop),
        .pop_data (cmd_head),
        .empty    (cmd_empty)
    );

    div_core u_core (
        .clk      (clk),
        .rst      (rst),
        .cmd_pop  (cmd_pop),
        .cmd_data (cmd_head),
        .cmd_empty(cmd_empty),
        .res_push (res_push),
        .res_data (res_in),
        .res_full (res_full)
    );

    op_fifo #(
        .WIDTH(div_pkg::RES_W),
        .DEPTH(RES_DEPTH)
    ) res_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (res_push),
        .push_data(res_in),
        .full     (res_full),
        .pop      (res_pop),
        .pop_data (res_head),
        .empty    (res_empty)
    );

endmodule

//--- verification/div_model.svh
`ifndef DIV_MODEL_SVH
`define DIV_MODEL_SVH

    // ******************************
    // RISC-V M extension divide.
    // ******************************
    // returns {quotient, remainder}.
    function automatic div_pkg::res_word_t riscv_divide(
        input div_pkg::xlen_t a,
        input div_pkg::xlen_t b,
        input logic           sgn,
        input logic           w
    );
        longint         sa;
        longint         sb;
        int             sa_w;
        int             sb_w;
        div_pkg::half_t ua_w;
        div_pkg::half_t ub_w;
        div_pkg::half_t q_w;
        div_pkg::half_t r_w;
        div_pkg::xlen_t q;
        div_pkg::xlen_t r;
        sa   = a;
        sb   = b;
        ua_w = a[31:0];  // W forms look at the low word only.
        ub_w = b[31:0];
        sa_w = ua_w;
        sb_w = ub_w;
        if (w) begin
            if (ub_w == '0) begin
                q_w = '1;
                r_w = ua_w;
            end else if (sgn && sa_w == 32'sh80000000 && sb_w == -1) begin
                q_w = ua_w;
                r_w = '0;
            end else if (sgn) begin
                q_w = sa_w / sb_w;
                r_w = sa_w % sb_w;
            end else begin
                q_w = ua_w / ub_w;
                r_w = ua_w % ub_w;
            end
            q = {{32{q_w[31]}}, q_w};  // results are sign-extended.
            r = {{32{r_w[31]}}, r_w};
        end else begin
            if (b == '0) begin
                q = '1;
                r = a;
            end else if (sgn && sa == 64'sh8000000000000000 && sb == -1) begin
                q = a;
                r = '0;
            end else if (sgn) begin
                q = sa / sb;
                r = sa % sb;
            end else begin
                q = a / b;
                r = a % b;
            end
        end
        return {q, r};
    endfunction

`endif

//--- verification/div_tb.sv
`timescale 1ns/100ps

module div_tb;

    localparam int CMD_DEPTH   = 4;
    localparam int RES_DEPTH   = 2;
    localparam int N_UNSIGNED  = 200;
    localparam int N_SIGNED    = 200;
    localparam int N_WORD      = 100;
    localparam int N_SPECIAL   = 6;
    localparam int BP_OPS      = CMD_DEPTH + RES_DEPTH + 2;
    localparam int HOLD_CYCLES = 300;
    localparam int TOTAL_OPS   = 1 + N_UNSIGNED + N_SIGNED + N_WORD + N_SPECIAL + BP_OPS;
    localparam int WATCHDOG_NS = TOTAL_OPS * 80 * 8 + 10000;

    logic             clk;
    logic             rst;
    logic             cyc;
    logic             stb;
    logic             we;
    wb_pkg::wb_addr_t adr;
    wb_pkg::wb_data_t dat_w;
    wb_pkg::wb_data_t dat_r;
    logic             ack;

    logic [31:0] rng;
    int          errors;
    int          pass_cnt;
    int          fail_cnt;
    logic        abort_hold;
    logic        saw_cmd_full;

    `include "div_model.svh"

    div_unit_top #(
        .CMD_DEPTH(CMD_DEPTH),
        .RES_DEPTH(RES_DEPTH)
    ) uut (
        .clk  (clk),
        .rst  (rst),
        .cyc  (cyc),
        .stb  (stb),
        .we   (we),
        .adr  (adr),
        .dat_w(dat_w),
        .dat_r(dat_r),
        .ack  (ack)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("simulation timed out waiting for the DUT");
        $display("STATUS: FAIL");
        $finish;
    end

    // ******************************
    // random numbers.
    // ******************************
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw(output logic [31:0] v);
        rng = xorshift32(rng);
        v   = rng;
    endtask

    // operand biased towards zero, small and most negative values.
    task automatic rand_operand(output div_pkg::xlen_t v);
        logic [31:0] hi;
        logic [31:0] lo;
        logic [31:0] sel;
        draw(hi);
        draw(lo);
        draw(sel);
        case (sel[3:0])
            4'd0:       v = '0;
            4'd1:       v = {1'b1, 63'b0};
            4'd2, 4'd3: v = {56'b0, lo[7:0]};
            4'd4:       v = {32'b0, lo};
            default:    v = {hi, lo};
        endcase
        if (sel[4] && sel[3:0] > 4'd1) begin
            v = -v;
        end
    endtask

    // ******************************
    // wishbone master.
    // ******************************
    task automatic wb_write(input wb_pkg::wb_addr_t a, input wb_pkg::wb_data_t d);
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = a;
        dat_w = d;
        @(negedge clk);
        while (!ack) begin
            @(negedge clk);
        end
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wb_read(input wb_pkg::wb_addr_t a, output wb_pkg::wb_data_t d);
        @(negedge clk);
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = a;
        @(negedge clk);
        while (!ack) begin
            @(negedge clk);
        end
        d   = dat_r;
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    // control write that gives up once abort_hold is raised.
    task automatic try_ctrl_write(input wb_pkg::wb_data_t d, output logic acked);
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = wb_pkg::REG_CTRL;
        dat_w = d;
        @(negedge clk);
        while (!ack && !abort_hold) begin
            @(negedge clk);
        end
        acked = ack;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
    endtask

    // ******************************
    // checks and operations.
    // ******************************
    task automatic check_xlen(input string what, input div_pkg::xlen_t got,
                              input div_pkg::xlen_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %h, expected %h", $time, what, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic check_status(input string what, input wb_pkg::wb_data_t got,
                                input wb_pkg::wb_data_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %h, expected %h", $time, what, got, exp);
            errors = errors + 1;
        end
    endtask

    function automatic wb_pkg::wb_data_t ctrl_word(input logic sgn, input logic w);
        wb_pkg::wb_data_t c;
        c = '0;
        c[wb_pkg::CTRL_SIGNED_BIT] = sgn;
        c[wb_pkg::CTRL_DIVW_BIT]   = w;
        return c;
    endfunction

    task automatic load_operands(input div_pkg::xlen_t a, input div_pkg::xlen_t b);
        wb_write(wb_pkg::REG_DIVIDEND, a);
        wb_write(wb_pkg::REG_DIVISOR, b);
    endtask

    task automatic wait_result();
        wb_pkg::wb_data_t st;
        st = '0;
        while (!st[wb_pkg::STAT_RESULT_BIT]) begin
            wb_read(wb_pkg::REG_STATUS, st);
            if (st[wb_pkg::STAT_CMD_FULL_BIT]) begin
                saw_cmd_full = 1'b1;
            end
        end
    endtask

    task automatic collect_result(input string name, input div_pkg::xlen_t a,
                                  input div_pkg::xlen_t b, input logic sgn, input logic w);
        div_pkg::res_word_t exp;
        div_pkg::xlen_t     q;
        div_pkg::xlen_t     r;
        exp = riscv_divide(a, b, sgn, w);
        wait_result();
        wb_read(wb_pkg::REG_QUOTIENT, q);
        wb_read(wb_pkg::REG_REMAINDER, r);  // pops the head.
        check_xlen({name, " quotient"}, q, exp[127:64]);
        check_xlen({name, " remainder"}, r, exp[63:0]);
    endtask

    task automatic run_op(input string name, input div_pkg::xlen_t a,
                          input div_pkg::xlen_t b, input logic sgn, input logic w);
        wb_pkg::wb_data_t st;
        load_operands(a, b);
        wb_write(wb_pkg::REG_CTRL, ctrl_word(sgn, w));
        collect_result(name, a, b, sgn, w);
        wb_read(wb_pkg::REG_STATUS, st);
        check_status({name, " status"}, st, '0);
    endtask

    task automatic end_test(input string name, input int err_before);
        if (errors == err_before) begin
            pass_cnt = pass_cnt + 1;
            $display("test %s: ok", name);
        end else begin
            fail_cnt = fail_cnt + 1;
            $display("test %s: %0d mismatches", name, errors - err_before);
        end
    endtask

    // ******************************
    // test sequence.
    // ******************************
    initial begin
        div_pkg::xlen_t   a;
        div_pkg::xlen_t   b;
        div_pkg::xlen_t   bp_a [BP_OPS];
        div_pkg::xlen_t   bp_b [BP_OPS];
        logic             bp_s [BP_OPS];
        logic             bp_w [BP_OPS];
        wb_pkg::wb_data_t st;
        logic [31:0]      r32;
        logic             early_ack;
        int               mark;
        rng          = 32'h20184f10;
        errors       = 0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        abort_hold   = 1'b0;
        saw_cmd_full = 1'b0;
        early_ack    = 1'b0;
        cyc          = 1'b0;
        stb          = 1'b0;
        we           = 1'b0;
        adr          = '0;
        dat_w        = '0;
        rst          = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        mark = errors;
        wb_read(wb_pkg::REG_STATUS, st);
        check_status("reset status", st, '0);
        wb_read(wb_pkg::REG_QUOTIENT, a);
        check_xlen("reset quotient", a, '0);
        wb_read(wb_pkg::REG_REMAINDER, a);
        check_xlen("reset remainder", a, '0);
        end_test("reset", mark);

        mark = errors;
        for (int i = 0; i < N_UNSIGNED; i++) begin
            rand_operand(a);
            rand_operand(b);
            run_op($sformatf("unsigned #%0d", i), a, b, 1'b0, 1'b0);
        end
        end_test("unsigned 64-bit", mark);

        mark = errors;
        for (int i = 0; i < N_SIGNED; i++) begin
            rand_operand(a);
            rand_operand(b);
            run_op($sformatf("signed #%0d", i), a, b, 1'b1, 1'b0);
        end
        end_test("signed 64-bit", mark);

        mark = errors;
        for (int i = 0; i < N_WORD; i++) begin
            rand_operand(a);
            rand_operand(b);
            draw(r32);
            a[63:32] = r32;  // junk that W forms must ignore.
            draw(r32);
            b[63:32] = r32;
            run_op($sformatf("word #%0d", i), a, b, r32[0], 1'b1);
        end
        end_test("W forms", mark);

        mark = errors;
        for (int m = 0; m < 4; m++) begin
            rand_operand(a);
            draw(r32);
            b = m[1] ? {r32, 32'b0} : '0;
            run_op($sformatf("divide by zero mode %0d", m), a, b, m[0], m[1]);
        end
        run_op("overflow 64", {1'b1, 63'b0}, '1, 1'b1, 1'b0);
        draw(r32);
        a = {r32, 32'h80000000};
        draw(r32);
        b = {r32, 32'hffffffff};
        run_op("overflow W", a, b, 1'b1, 1'b1);
        end_test("special cases", mark);

        mark = errors;
        for (int i = 0; i < BP_OPS; i++) begin
            rand_operand(bp_a[i]);
            rand_operand(bp_b[i]);
            draw(r32);
            bp_s[i] = r32[0];
            bp_w[i] = r32[1];
        end
        for (int i = 0; i < BP_OPS - 1; i++) begin
            load_operands(bp_a[i], bp_b[i]);
            wb_write(wb_pkg::REG_CTRL, ctrl_word(bp_s[i], bp_w[i]));
        end
        // both FIFOs and the core are now occupied, nothing leaves without a read.
        load_operands(bp_a[BP_OPS-1], bp_b[BP_OPS-1]);
        abort_hold = 1'b0;
        fork
            try_ctrl_write(ctrl_word(bp_s[BP_OPS-1], bp_w[BP_OPS-1]), early_ack);
            begin
                repeat (HOLD_CYCLES) @(negedge clk);
                abort_hold = 1'b1;
            end
        join
        if (early_ack) begin
            $display("back-pressure: last control write was acknowledged at %0t", $time);
            $display("back-pressure: the command FIFO should have held it off");
            errors = errors + 1;
        end
        collect_result("back-pressure #0", bp_a[0], bp_b[0], bp_s[0], bp_w[0]);
        saw_cmd_full = 1'b0;
        if (!early_ack) begin
            wb_write(wb_pkg::REG_CTRL, ctrl_word(bp_s[BP_OPS-1], bp_w[BP_OPS-1]));
        end
        for (int i = 1; i < BP_OPS; i++) begin
            collect_result($sformatf("back-pressure #%0d", i), bp_a[i], bp_b[i],
                           bp_s[i], bp_w[i]);
        end
        if (!saw_cmd_full) begin
            $display("back-pressure: status never showed the command FIFO full");
            errors = errors + 1;
        end
        end_test("back-pressure", mark);

        $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+verification
design/div_pkg.sv
design/wb_pkg.sv
design/op_fifo.sv
design/div_core.sv
design/wb_div_regs.sv
design/div_unit_top.sv
verification/div_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := div_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; status=$$?; echo "$$out"; \
	[ $$status -eq 0 ] && echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
